// ==== verilog/vend_pkg.sv ====
package vend_pkg;

    ////////////////////////////////////////////////////////////
    // basic types
    ////////////////////////////////////////////////////////////

    // 0 is no product, products are 1 to 4
    typedef logic [2:0] prod_id_t;
    typedef logic [3:0] stock_t;
    // amounts in hundreds of won
    typedef logic [6:0] money_t;

    localparam int n_prod = 4;

    ////////////////////////////////////////////////////////////
    // product tables, indexed by product id minus one
    ////////////////////////////////////////////////////////////

    localparam money_t prod_price [n_prod] = '{7'd10, 7'd12, 7'd15, 7'd18};
    localparam stock_t prod_init_stock [n_prod] = '{4'd9, 4'd1, 4'd0, 4'd4};

    // restock ceiling per product
    localparam stock_t stock_limit = 4'd9;

    // coin values
    localparam money_t coin_small = 7'd1;
    localparam money_t coin_mid = 7'd5;
    localparam money_t coin_large = 7'd10;

    // all four counts, entry 0 is product 1
    typedef stock_t [n_prod-1:0] stock_vec_t;

    typedef struct packed {
        logic   sold;
        money_t price;
    } sale_t;

endpackage

// ==== verilog/panel_pkg.sv ====
package panel_pkg;

    // bit positions in the one-shot button word
    localparam int btn_coin_large = 0;
    localparam int btn_coin_mid = 1;
    localparam int btn_coin_small = 2;
    localparam int btn_return = 3;
    localparam int btn_down = 4;
    localparam int btn_add = 5;
    localparam int btn_select = 7;
    localparam int btn_buy = 9;
    localparam int btn_up = 10;
    localparam int btn_admin = 11;

    typedef logic [1:0] cursor_t;

    // one command per cycle, coin is zero when no coin
    typedef struct packed {
        vend_pkg::money_t   coin;
        logic               buy;
        logic               refund;
        logic               restock;
        vend_pkg::prod_id_t item;
    } panel_cmd_t;

    typedef struct packed {
        cursor_t            cursor;
        vend_pkg::prod_id_t selected;
        logic               admin;
    } panel_state_t;

endpackage

// ==== verilog/panel_decoder.sv ====
module panel_decoder (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [11:0]            button_sw_oneshot,
    input  vend_pkg::stock_vec_t   stock,
    output panel_pkg::panel_cmd_t  cmd,
    output panel_pkg::panel_state_t state
);

    localparam panel_pkg::cursor_t cursor_max = panel_pkg::cursor_t'(vend_pkg::n_prod - 1);

    logic [2:0]         coin_bits;
    vend_pkg::money_t   coin_value;
    vend_pkg::prod_id_t cursor_item;

    // coin buttons, small on top
    always_comb begin
        coin_bits = {button_sw_oneshot[panel_pkg::btn_coin_small],
                     button_sw_oneshot[panel_pkg::btn_coin_mid],
                     button_sw_oneshot[panel_pkg::btn_coin_large]};
        case (coin_bits)
            3'b100:  coin_value = vend_pkg::coin_small;
            3'b010:  coin_value = vend_pkg::coin_mid;
            3'b001:  coin_value = vend_pkg::coin_large;
            // two coins at once count as nothing
            default: coin_value = '0;
        endcase
        cursor_item = 3'(state.cursor) + 3'd1;
    end

    ////////////////////////////////////////////////////////////
    // button priority chain
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            cmd <= '0;
            state <= '0;
        end else begin
            cmd <= '0;
            if (button_sw_oneshot[panel_pkg::btn_up] || button_sw_oneshot[panel_pkg::btn_down]) begin
                if (button_sw_oneshot[panel_pkg::btn_up]) begin
                    if (state.cursor != '0)
                        state.cursor <= state.cursor - 1'b1;
                end else if (state.cursor != cursor_max) begin
                    state.cursor <= state.cursor + 1'b1;
                end
            end else if (button_sw_oneshot[panel_pkg::btn_select]) begin
                // same product again deselects
                if (state.selected == cursor_item)
                    state.selected <= '0;
                else if (stock[state.cursor] != '0)
                    state.selected <= cursor_item;
            end else if (coin_bits != '0) begin
                cmd.coin <= coin_value;
            end else if (button_sw_oneshot[panel_pkg::btn_buy]) begin
                if (state.selected != '0) begin
                    cmd.buy <= 1'b1;
                    cmd.item <= state.selected;
                    state.selected <= '0;
                end
            end else if (button_sw_oneshot[panel_pkg::btn_return]) begin
                cmd.refund <= 1'b1;
            end else if (button_sw_oneshot[panel_pkg::btn_add]) begin
                if (state.admin)
                    cmd.restock <= 1'b1;
            end else if (button_sw_oneshot[panel_pkg::btn_admin]) begin
                state.admin <= ~state.admin;
            end
        end
    end

    a_one_cmd: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({cmd.buy, cmd.refund, cmd.restock, cmd.coin != '0}));

endmodule

// ==== verilog/stock_keeper.sv ====
module stock_keeper (
    input  logic                  clk,
    input  logic                  rst,
    input  panel_pkg::panel_cmd_t cmd,
    input  panel_pkg::cursor_t    cursor,
    input  vend_pkg::money_t      top,
    output vend_pkg::stock_vec_t  stock,
    output vend_pkg::stock_t      count_at_cursor,
    output vend_pkg::sale_t       sale,
    output logic                  short
);

    logic [1:0]       buy_idx;
    vend_pkg::money_t buy_price;
    logic             in_stock;
    logic             enough;

    // purchase decision, same cycle as the buy command
    always_comb begin
        buy_idx = 2'(cmd.item - 3'd1);
        buy_price = vend_pkg::prod_price[buy_idx];
        in_stock = stock[buy_idx] != '0;
        enough = top >= buy_price;
        sale.sold = cmd.buy && in_stock && enough;
        sale.price = buy_price;
    end

    assign count_at_cursor = stock[cursor];

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < vend_pkg::n_prod; i++)
                stock[i] <= vend_pkg::prod_init_stock[i];
            short <= 1'b0;
        end else begin
            // not enough credit, even if sold out
            short <= cmd.buy && !enough;
            if (sale.sold)
                stock[buy_idx] <= stock[buy_idx] - 1'b1;
            else if (cmd.restock && stock[cursor] < vend_pkg::stock_limit)
                stock[cursor] <= stock[cursor] + 1'b1;
        end
    end

    for (genvar g = 0; g < vend_pkg::n_prod; g++) begin : g_limit
        a_stock_limit: assert property (@(posedge clk) disable iff (!rst)
            stock[g] <= vend_pkg::stock_limit);
    end

endmodule

// ==== verilog/credit_stack.sv ====
module credit_stack #(
    parameter int history_depth = 9
) (
    input  logic             clk,
    input  logic             rst,
    input  vend_pkg::money_t coin,
    input  vend_pkg::sale_t  sale,
    input  logic             pop,
    input  logic             dec,
    output vend_pkg::money_t top,
    output logic             empty,
    output logic             flattened
);

    // entry 0 is the newest running total
    vend_pkg::money_t hist [history_depth];

    ////////////////////////////////////////////////////////////
    // history update, coin first
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < history_depth; i++)
                hist[i] <= '0;
            flattened <= 1'b0;
        end else if (coin != '0) begin
            // oldest entry falls off the end
            for (int i = 1; i < history_depth; i++)
                hist[i] <= hist[i-1];
            hist[0] <= hist[0] + coin;
        end else if (sale.sold) begin
            // after a sale only the remaining credit is kept
            hist[0] <= hist[0] - sale.price;
            for (int i = 1; i < history_depth; i++)
                hist[i] <= '0;
            flattened <= 1'b1;
        end else if (pop) begin
            for (int i = 0; i < history_depth - 1; i++)
                hist[i] <= hist[i+1];
            hist[history_depth-1] <= '0;
        end else if (dec) begin
            hist[0] <= hist[0] - 1'b1;
            if (hist[0] == vend_pkg::money_t'(1))
                flattened <= 1'b0;
        end
    end

    assign top = hist[0];

    always_comb begin
        empty = 1'b1;
        for (int i = 0; i < history_depth; i++) begin
            if (hist[i] != '0)
                empty = 1'b0;
        end
    end

    // refund steps never collide with each other or a coin
    a_step_excl: assert property (@(posedge clk) disable iff (!rst)
        !(pop && dec) && !((pop || dec) && coin != '0));

endmodule

// ==== verilog/refund_sequencer.sv ====
module refund_sequencer #(
    parameter int coin_hold_cycles = 2000000,
    parameter int refund_step_cycles = 1000000
) (
    input  logic             clk,
    input  logic             rst,
    input  vend_pkg::money_t coin,
    input  logic             refund,
    input  vend_pkg::money_t top,
    input  logic             empty,
    input  logic             flattened,
    output logic             pop,
    output logic             dec,
    output logic             busy,
    output vend_pkg::money_t display
);

    localparam int hold_w = $clog2(coin_hold_cycles + 1);
    localparam int step_w = $clog2(refund_step_cycles + 1);

    logic             holding;
    logic [hold_w-1:0] hold_cnt;
    vend_pkg::money_t hold_val;
    logic [step_w-1:0] step_cnt;
    logic             step_due;
    logic             done;
    logic             active;
    logic             step;

    ////////////////////////////////////////////////////////////
    // coin display hold
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            holding <= 1'b0;
            hold_cnt <= '0;
        end else if (coin != '0) begin
            // a new coin restarts the hold
            holding <= 1'b1;
            hold_cnt <= '0;
        end else if (holding) begin
            if (hold_cnt == hold_w'(coin_hold_cycles - 1))
                holding <= 1'b0;
            else
                hold_cnt <= hold_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (coin != '0)
            hold_val <= coin;
    end

    assign display = holding ? hold_val : top;

    ////////////////////////////////////////////////////////////
    // refund steps, paused during a coin hold
    ////////////////////////////////////////////////////////////
    assign step_due = step_cnt == step_w'(refund_step_cycles - 1);
    assign done = flattened ? (top == '0) : empty;
    assign active = busy && !holding && coin == '0;
    assign step = active && step_due && !done;
    assign pop = step && !flattened;
    assign dec = step && flattened;

    always_ff @(posedge clk) begin
        if (!rst) begin
            busy <= 1'b0;
            step_cnt <= '0;
        end else if (refund) begin
            busy <= 1'b1;
            step_cnt <= '0;
        end else if (active) begin
            if (done)
                busy <= 1'b0;
            else if (step_due)
                step_cnt <= '0;
            else
                step_cnt <= step_cnt + 1'b1;
        end
    end

endmodule

// ==== verilog/vending_top.sv ====
module vending_top #(
    parameter int history_depth = 9,
    parameter int coin_hold_cycles = 2000000,
    parameter int refund_step_cycles = 1000000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic [11:0]         button_sw_oneshot,
    output vend_pkg::money_t    display_money,
    output vend_pkg::stock_t    prod_count_current,
    output panel_pkg::cursor_t  cursor,
    output vend_pkg::prod_id_t  selected_item,
    output logic                admin_mode,
    output logic                sold,
    output logic                short,
    output logic                refund_busy
);

    panel_pkg::panel_cmd_t   cmd;
    panel_pkg::panel_state_t state;
    vend_pkg::stock_vec_t    stock;
    vend_pkg::sale_t         sale;
    vend_pkg::money_t        top;
    logic                    empty;
    logic                    flattened;
    logic                    pop;
    logic                    dec;

    assign cursor = state.cursor;
    assign selected_item = state.selected;
    assign admin_mode = state.admin;
    assign sold = sale.sold;

    ////////////////////////////////////////////////////////////
    // panel and stock
    ////////////////////////////////////////////////////////////
    panel_decoder panel_decoder_i (
        .clk               (clk),
        .rst               (rst),
        .button_sw_oneshot (button_sw_oneshot),
        .stock             (stock),
        .cmd               (cmd),
        .state             (state)
    );

    stock_keeper stock_keeper_i (
        .clk             (clk),
        .rst             (rst),
        .cmd             (cmd),
        .cursor          (state.cursor),
        .top             (top),
        .stock           (stock),
        .count_at_cursor (prod_count_current),
        .sale            (sale),
        .short           (short)
    );

    ////////////////////////////////////////////////////////////
    // credit history and refund
    ////////////////////////////////////////////////////////////
    credit_stack #(
        .history_depth (history_depth)
    ) credit_stack_i (
        .clk       (clk),
        .rst       (rst),
        .coin      (cmd.coin),
        .sale      (sale),
        .pop       (pop),
        .dec       (dec),
        .top       (top),
        .empty     (empty),
        .flattened (flattened)
    );

    refund_sequencer #(
        .coin_hold_cycles   (coin_hold_cycles),
        .refund_step_cycles (refund_step_cycles)
    ) refund_sequencer_i (
        .clk       (clk),
        .rst       (rst),
        .coin      (cmd.coin),
        .refund    (cmd.refund),
        .top       (top),
        .empty     (empty),
        .flattened (flattened),
        .pop       (pop),
        .dec       (dec),
        .busy      (refund_busy),
        .display   (display_money)
    );

endmodule

// ==== test/vending_tb.sv ====
module vending_tb;

    localparam int period = 100;
    localparam int coin_hold = 4;
    localparam int refund_step = 3;
    localparam int reset_len = 4;

    // worst-case cycles per test, summed for the watchdog
    localparam int coin_cycles = coin_hold + 4;
    localparam int refund_limit = 110 * refund_step + 10;
    localparam int budget = 3 * (reset_len + 8 + 6 * coin_cycles)
        + (reset_len + 40)
        + 2 * (reset_len + 20 + 13 * coin_cycles)
        + 2 * (reset_len + 30 + 13 * coin_cycles + refund_limit)
        + (reset_len + 60);
    localparam int watchdog_cycles = budget + 200;

    logic               clk;
    logic               rst;
    logic [11:0]        buttons;
    vend_pkg::money_t   display_money;
    vend_pkg::stock_t   prod_count_current;
    panel_pkg::cursor_t cursor;
    vend_pkg::prod_id_t selected_item;
    logic               admin_mode;
    logic               sold;
    logic               short;
    logic               refund_busy;

    int          errors = 0;
    int          test_errs = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] rng = 32'd72;
    int          sum;
    int          totals[$];
    int          seen[$];
    int          sold_cnt;
    int          short_cnt;

    vending_top #(
        .coin_hold_cycles   (coin_hold),
        .refund_step_cycles (refund_step)
    ) dut_i (
        .clk                (clk),
        .rst                (rst),
        .button_sw_oneshot  (buttons),
        .display_money      (display_money),
        .prod_count_current (prod_count_current),
        .cursor             (cursor),
        .selected_item      (selected_item),
        .admin_mode         (admin_mode),
        .sold               (sold),
        .short              (short),
        .refund_busy        (refund_busy)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #(watchdog_cycles * period);
        $display("watchdog expired after %0d cycles, run stopped", watchdog_cycles);
        $display("Result: FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // reference tables and helpers
    ////////////////////////////////////////////////////////////

    function automatic int price_of(input int item);
        case (item)
            1: return 10;
            2: return 12;
            3: return 15;
            default: return 18;
        endcase
    endfunction

    function automatic int init_stock_of(input int item);
        case (item)
            1: return 9;
            2: return 1;
            3: return 0;
            default: return 4;
        endcase
    endfunction

    function automatic int coin_button(input int value);
        case (value)
            1: return panel_pkg::btn_coin_small;
            5: return panel_pkg::btn_coin_mid;
            default: return panel_pkg::btn_coin_large;
        endcase
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_coin(output int value);
        rng = xorshift32(rng);
        case (rng % 3)
            0: value = 1;
            1: value = 5;
            default: value = 10;
        endcase
    endtask

    task automatic report_err(input string test, input string what, input int exp, input int act);
        $display("ERR %s %s expected %0d actual %0d", test, what, exp, act);
        test_errs++;
    endtask

    task automatic reset_dut();
        @(negedge clk);
        rst = 1'b0;
        buttons = '0;
        repeat (reset_len) @(negedge clk);
        rst = 1'b1;
        sum = 0;
        totals.delete();
    endtask

    task automatic end_test(input string name);
        tests_run++;
        errors += test_errs;
        if (test_errs == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    // one-cycle pulse, returns just after the edge that took it
    task automatic press(input int idx);
        @(negedge clk);
        buttons = '0;
        buttons[idx] = 1'b1;
        @(negedge clk);
        buttons = '0;
    endtask

    task automatic press_and_count(input int idx, input int window);
        @(negedge clk);
        buttons[idx] = 1'b1;
        sold_cnt = 0;
        short_cnt = 0;
        repeat (window) begin
            @(negedge clk);
            buttons = '0;
            if (sold)
                sold_cnt++;
            if (short)
                short_cnt++;
        end
    endtask

    task automatic add_coin(input int value);
        press(coin_button(value));
        sum += value;
        totals.push_back(sum);
        repeat (coin_hold + 2) @(negedge clk);
    endtask

    // return, then log every display change until busy drops
    task automatic run_refund(input string name);
        int  last;
        int  n;
        logic busy_seen;
        logic done;
        press(panel_pkg::btn_return);
        seen.delete();
        last = display_money;
        n = 0;
        busy_seen = 1'b0;
        done = 1'b0;
        while (!done && n < refund_limit) begin
            @(negedge clk);
            n++;
            if (display_money != last) begin
                last = display_money;
                seen.push_back(last);
            end
            if (refund_busy)
                busy_seen = 1'b1;
            else if (busy_seen)
                done = 1'b1;
        end
        if (!done) begin
            $display("%s: refund_busy did not fall within %0d cycles", name, n);
            test_errs++;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_coin_display();
        int len;
        int c;
        for (int s = 0; s < 3; s++) begin
            reset_dut();
            rng = xorshift32(rng);
            len = 1 + rng % 6;
            for (int i = 0; i < len; i++) begin
                next_coin(c);
                press(coin_button(c));
                sum += c;
                @(negedge clk);
                if (display_money !== c)
                    report_err("coin_display", "coin shown", c, display_money);
                repeat (coin_hold + 1) @(negedge clk);
                if (display_money !== sum)
                    report_err("coin_display", "running sum", sum, display_money);
            end
        end
        end_test("coin_display");
    endtask

    task automatic test_cursor_stock();
        reset_dut();
        press(panel_pkg::btn_up);
        if (cursor !== 0)
            report_err("cursor_stock", "cursor at top", 0, cursor);
        if (prod_count_current !== init_stock_of(1))
            report_err("cursor_stock", "count 1", init_stock_of(1), prod_count_current);
        for (int p = 1; p < 4; p++) begin
            press(panel_pkg::btn_down);
            if (cursor !== p)
                report_err("cursor_stock", "cursor down", p, cursor);
            if (prod_count_current !== init_stock_of(p + 1))
                report_err("cursor_stock", "count", init_stock_of(p + 1), prod_count_current);
        end
        press(panel_pkg::btn_down);
        if (cursor !== 3)
            report_err("cursor_stock", "cursor at bottom", 3, cursor);
        // product 3 is sold out
        press(panel_pkg::btn_up);
        press(panel_pkg::btn_select);
        if (selected_item !== 0)
            report_err("cursor_stock", "empty product select", 0, selected_item);
        press(panel_pkg::btn_up);
        press(panel_pkg::btn_up);
        press(panel_pkg::btn_select);
        if (selected_item !== 1)
            report_err("cursor_stock", "select", 1, selected_item);
        press(panel_pkg::btn_select);
        if (selected_item !== 0)
            report_err("cursor_stock", "deselect", 0, selected_item);
        end_test("cursor_stock");
    endtask

    task automatic test_purchase();
        int c;
        reset_dut();
        while (sum < 12) begin
            next_coin(c);
            add_coin(c);
        end
        press(panel_pkg::btn_select);
        press_and_count(panel_pkg::btn_buy, 4);
        if (sold_cnt != 1)
            report_err("purchase", "sold pulses", 1, sold_cnt);
        if (short_cnt != 0)
            report_err("purchase", "short pulses", 0, short_cnt);
        if (display_money !== sum - price_of(1))
            report_err("purchase", "credit", sum - price_of(1), display_money);
        if (prod_count_current !== init_stock_of(1) - 1)
            report_err("purchase", "count", init_stock_of(1) - 1, prod_count_current);
        if (selected_item !== 0)
            report_err("purchase", "selection", 0, selected_item);
        end_test("purchase");
    endtask

    task automatic test_short_money();
        int c;
        reset_dut();
        next_coin(c);
        add_coin(c);
        repeat (2) begin
            next_coin(c);
            if (sum + c < price_of(4))
                add_coin(c);
        end
        repeat (3) press(panel_pkg::btn_down);
        press(panel_pkg::btn_select);
        press_and_count(panel_pkg::btn_buy, 4);
        if (short_cnt != 1)
            report_err("short_money", "short pulses", 1, short_cnt);
        if (sold_cnt != 0)
            report_err("short_money", "sold pulses", 0, sold_cnt);
        if (prod_count_current !== init_stock_of(4))
            report_err("short_money", "count", init_stock_of(4), prod_count_current);
        if (display_money !== sum)
            report_err("short_money", "credit", sum, display_money);
        end_test("short_money");
    endtask

    task automatic test_refund();
        int c;
        int n;
        int credit;
        int exp;
        // coins only, history walks back
        reset_dut();
        rng = xorshift32(rng);
        n = 2 + rng % 4;
        repeat (n) begin
            next_coin(c);
            add_coin(c);
        end
        run_refund("refund");
        if (seen.size() != n)
            report_err("refund", "history steps", n, seen.size());
        for (int i = 0; i < seen.size() && i < n; i++) begin
            exp = (i < n - 1) ? totals[n - 2 - i] : 0;
            if (seen[i] != exp)
                report_err("refund", "history value", exp, seen[i]);
        end
        if (display_money !== 0)
            report_err("refund", "final credit", 0, display_money);
        // after a sale, one unit per step
        reset_dut();
        while (sum < 13) begin
            next_coin(c);
            add_coin(c);
        end
        press(panel_pkg::btn_select);
        press_and_count(panel_pkg::btn_buy, 4);
        credit = sum - price_of(1);
        run_refund("refund");
        if (seen.size() != credit)
            report_err("refund", "unit steps", credit, seen.size());
        for (int i = 0; i < seen.size() && i < credit; i++) begin
            if (seen[i] != credit - 1 - i)
                report_err("refund", "unit value", credit - 1 - i, seen[i]);
        end
        if (display_money !== 0)
            report_err("refund", "final credit", 0, display_money);
        end_test("refund");
    endtask

    task automatic test_restock();
        int exp;
        reset_dut();
        press(panel_pkg::btn_down);
        press(panel_pkg::btn_add);
        @(negedge clk);
        if (prod_count_current !== init_stock_of(2))
            report_err("restock", "add without admin", init_stock_of(2), prod_count_current);
        press(panel_pkg::btn_admin);
        if (admin_mode !== 1'b1)
            report_err("restock", "admin on", 1, admin_mode);
        exp = init_stock_of(2);
        repeat (10) begin
            press(panel_pkg::btn_add);
            @(negedge clk);
            if (exp < 9)
                exp++;
            if (prod_count_current !== exp)
                report_err("restock", "count", exp, prod_count_current);
        end
        press(panel_pkg::btn_admin);
        if (admin_mode !== 1'b0)
            report_err("restock", "admin off", 0, admin_mode);
        // product 3 is well below the ceiling
        press(panel_pkg::btn_down);
        press(panel_pkg::btn_add);
        @(negedge clk);
        if (prod_count_current !== init_stock_of(3))
            report_err("restock", "add after admin off", init_stock_of(3), prod_count_current);
        end_test("restock");
    endtask

    initial begin
        rst = 1'b0;
        buttons = '0;
        test_coin_display();
        test_cursor_stock();
        test_purchase();
        test_short_money();
        test_refund();
        test_restock();
        $display("tests %0d, failed %0d, check errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== filelist.f ====
verilog/vend_pkg.sv
verilog/panel_pkg.sv
verilog/panel_decoder.sv
verilog/stock_keeper.sv
verilog/credit_stack.sv
verilog/refund_sequencer.sv
verilog/vending_top.sv
test/vending_tb.sv

// ==== Bender.yml ====
package:
  name: vending

sources:
  - verilog/vend_pkg.sv
  - verilog/panel_pkg.sv
  - verilog/panel_decoder.sv
  - verilog/stock_keeper.sv
  - verilog/credit_stack.sv
  - verilog/refund_sequencer.sv
  - verilog/vending_top.sv
  - target: test
    files:
      - test/vending_tb.sv
